// ==== rtl/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Region nibble sits in the top address bits
`define SOC_REGION_LSB 28
`define REGION_RAM 4'h1
`define REGION_LED 4'h4
`define REGION_TIMER 4'hA

// On-chip RAM depth in words
`define RAM_WORDS 1024

`define LED_W 10

// Timer word indices from address bits 3:2
`define TMR_REG_COUNT 2'd0
`define TMR_REG_COMPARE 2'd1
`define TMR_REG_CTRL 2'd2

// Timer ctrl bits
`define TMR_CTRL_EN 0
`define TMR_CTRL_PEND 1

`endif

// ==== rtl/soc_bus_pkg.sv ====
`include "soc_consts.svh"

package soc_bus_pkg;

	// Address and data as seen on every bus segment
	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_DATA_W-1:0] data_t;

	// Top address nibble selecting a target
	typedef logic [`SOC_ADDR_W-1:`SOC_REGION_LSB] region_t;

	// Arbiter states
	typedef enum logic
	{
		ARB_IDLE,
		ARB_BUSY
	} arb_state_t;

	// Port holding the grant
	typedef enum logic [1:0]
	{
		M_DATA,
		M_DMA,
		M_INSTR
	} master_t;

endpackage

// ==== rtl/soc_periph_pkg.sv ====
`include "soc_consts.svh"

package soc_periph_pkg;

	// LED pattern
	typedef logic [`LED_W-1:0] led_t;

	// Timer count and compare value
	typedef logic [`SOC_DATA_W-1:0] timer_cnt_t;

	// Register word index, address bits 3:2
	typedef logic [1:0] reg_idx_t;

endpackage

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

interface mem_bus_if;

	// Request level, held by the master until ready
	logic request;
	// 1 means write
	logic rw;
	soc_bus_pkg::addr_t address;
	soc_bus_pkg::data_t wdata;

	// Single-cycle ready, rdata valid with it
	soc_bus_pkg::data_t rdata;
	logic ready;

	modport master
	(
		output request, rw, address, wdata,
		input rdata, ready
	);

	modport slave
	(
		input request, rw, address, wdata,
		output rdata, ready
	);

endinterface

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module bus_arbiter
(
	input logic clock,
	input logic i_rst_n,

	// Instruction port, reads only
	input logic i_ib_request,
	input soc_bus_pkg::addr_t i_ib_address,
	output logic o_ib_ready,
	output soc_bus_pkg::data_t o_ib_rdata,

	// Data port
	input logic i_db_request,
	input logic i_db_rw,
	input soc_bus_pkg::addr_t i_db_address,
	input soc_bus_pkg::data_t i_db_wdata,
	output logic o_db_ready,
	output soc_bus_pkg::data_t o_db_rdata,

	// DMA port
	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_bus_pkg::addr_t i_dma_address,
	input soc_bus_pkg::data_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_bus_pkg::data_t o_dma_rdata,

	mem_bus_if.master bus
);

	soc_bus_pkg::arb_state_t state;
	soc_bus_pkg::master_t grant;
	logic busy;

	assign busy = (state == soc_bus_pkg::ARB_BUSY);

	//============================================================
	// Grant FSM

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= soc_bus_pkg::ARB_IDLE;
			grant <= soc_bus_pkg::M_DATA;
		end
		else if (!busy)
		begin
			// Fixed priority, data first then DMA then instruction
			if (i_db_request || i_dma_request || i_ib_request)
				state <= soc_bus_pkg::ARB_BUSY;
			if (i_db_request)
				grant <= soc_bus_pkg::M_DATA;
			else if (i_dma_request)
				grant <= soc_bus_pkg::M_DMA;
			else if (i_ib_request)
				grant <= soc_bus_pkg::M_INSTR;
		end
		else if (bus.ready)
			state <= soc_bus_pkg::ARB_IDLE;
	end

	//============================================================
	// Shared bus fields from the granted port

	assign bus.request = busy;

	always_comb
	begin
		case (grant)
			soc_bus_pkg::M_DMA:
			begin
				bus.rw = i_dma_rw;
				bus.address = i_dma_address;
				bus.wdata = i_dma_wdata;
			end
			soc_bus_pkg::M_INSTR:
			begin
				bus.rw = 1'b0;
				bus.address = i_ib_address;
				bus.wdata = '0;
			end
			default:
			begin
				bus.rw = i_db_rw;
				bus.address = i_db_address;
				bus.wdata = i_db_wdata;
			end
		endcase
	end

	// Response goes back to the granted port only
	assign o_db_ready = busy && bus.ready && (grant == soc_bus_pkg::M_DATA);
	assign o_dma_ready = busy && bus.ready && (grant == soc_bus_pkg::M_DMA);
	assign o_ib_ready = busy && bus.ready && (grant == soc_bus_pkg::M_INSTR);

	assign o_db_rdata = (grant == soc_bus_pkg::M_DATA) ? bus.rdata : '0;
	assign o_dma_rdata = (grant == soc_bus_pkg::M_DMA) ? bus.rdata : '0;
	assign o_ib_rdata = (grant == soc_bus_pkg::M_INSTR) ? bus.rdata : '0;

endmodule

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module bus_decoder
(
	input logic clock,
	input logic i_rst_n,
	mem_bus_if.slave up,
	mem_bus_if.master ram_bus,
	mem_bus_if.master led_bus,
	mem_bus_if.master timer_bus
);

	soc_bus_pkg::region_t region;
	logic sel_ram;
	logic sel_led;
	logic sel_timer;
	logic sel_none;
	logic unm_ready;

	assign region = up.address[`SOC_ADDR_W-1:`SOC_REGION_LSB];

	assign sel_ram = (region == `REGION_RAM);
	assign sel_led = (region == `REGION_LED);
	assign sel_timer = (region == `REGION_TIMER);
	assign sel_none = !(sel_ram || sel_led || sel_timer);

	//============================================================
	// Forward to targets, request only to the selected one

	assign ram_bus.request = up.request && sel_ram;
	assign ram_bus.rw = up.rw;
	assign ram_bus.address = up.address;
	assign ram_bus.wdata = up.wdata;

	assign led_bus.request = up.request && sel_led;
	assign led_bus.rw = up.rw;
	assign led_bus.address = up.address;
	assign led_bus.wdata = up.wdata;

	assign timer_bus.request = up.request && sel_timer;
	assign timer_bus.rw = up.rw;
	assign timer_bus.address = up.address;
	assign timer_bus.wdata = up.wdata;

	// Unmapped regions still complete, one cycle later
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			unm_ready <= 1'b0;
		else
			unm_ready <= up.request && sel_none && !unm_ready;
	end

	//============================================================
	// Response mux

	assign up.ready = sel_ram ? ram_bus.ready :
		sel_led ? led_bus.ready :
		sel_timer ? timer_bus.ready :
		unm_ready;

	assign up.rdata = sel_ram ? ram_bus.rdata :
		sel_led ? led_bus.rdata :
		sel_timer ? timer_bus.rdata :
		'0;

endmodule

// ==== rtl/ram_block.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module ram_block #(
	parameter int WORDS = `RAM_WORDS
)
(
	input logic clock,
	mem_bus_if.slave bus
);

	localparam int IDX_W = $clog2(WORDS);

	soc_bus_pkg::data_t mem [WORDS];
	logic [IDX_W-1:0] idx;
	logic accept;
	logic ready_q;
	soc_bus_pkg::data_t rdata_q;

	// Word index, upper address bits alias modulo depth
	assign idx = bus.address[IDX_W+1:2];

	// Own ready cycle blocks a second accept
	assign accept = bus.request && !ready_q;

	always_ff @(posedge clock)
	begin
		ready_q <= accept;
		if (accept)
		begin
			if (bus.rw)
			begin
				mem[idx] <= bus.wdata;
				rdata_q <= '0;
			end
			else
				rdata_q <= mem[idx];
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

// ==== rtl/io_regs.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module io_regs
(
	input logic clock,
	input logic i_rst_n,
	mem_bus_if.slave led_bus,
	mem_bus_if.slave timer_bus,
	output soc_periph_pkg::led_t o_led,
	output logic o_timer_irq
);

	soc_periph_pkg::led_t led_q;
	logic led_ready;
	logic led_accept;

	soc_periph_pkg::timer_cnt_t tmr_count;
	soc_periph_pkg::timer_cnt_t tmr_compare;
	logic tmr_en;
	logic tmr_pend;
	logic tmr_ready;
	logic tmr_accept;
	soc_periph_pkg::reg_idx_t tmr_idx;
	soc_bus_pkg::data_t tmr_read;
	soc_bus_pkg::data_t tmr_rdata;

	//============================================================
	// LED register

	assign led_accept = led_bus.request && !led_ready;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			led_q <= '0;
			led_ready <= 1'b0;
		end
		else
		begin
			led_ready <= led_accept;
			if (led_accept && led_bus.rw)
				led_q <= led_bus.wdata[`LED_W-1:0];
		end
	end

	assign led_bus.ready = led_ready;
	assign led_bus.rdata = soc_bus_pkg::data_t'(led_q);
	assign o_led = led_q;

	//============================================================
	// Interval timer

	assign tmr_idx = timer_bus.address[3:2];
	assign tmr_accept = timer_bus.request && !tmr_ready;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			tmr_count <= '0;
			tmr_compare <= '0;
			tmr_en <= 1'b0;
			tmr_pend <= 1'b0;
			tmr_ready <= 1'b0;
		end
		else
		begin
			tmr_ready <= tmr_accept;
			// Count clock cycles, wrap on compare match
			if (tmr_en)
			begin
				if (tmr_count == tmr_compare)
				begin
					tmr_count <= '0;
					tmr_pend <= 1'b1;
				end
				else
					tmr_count <= tmr_count + 1'b1;
			end
			// Bus write overrides the counter update
			if (tmr_accept && timer_bus.rw)
			begin
				case (tmr_idx)
					`TMR_REG_COUNT: tmr_count <= timer_bus.wdata;
					`TMR_REG_COMPARE: tmr_compare <= timer_bus.wdata;
					`TMR_REG_CTRL:
					begin
						tmr_en <= timer_bus.wdata[`TMR_CTRL_EN];
						if (timer_bus.wdata[`TMR_CTRL_PEND])
							tmr_pend <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		tmr_read = '0;
		case (tmr_idx)
			`TMR_REG_COUNT: tmr_read = tmr_count;
			`TMR_REG_COMPARE: tmr_read = tmr_compare;
			`TMR_REG_CTRL:
			begin
				tmr_read[`TMR_CTRL_EN] = tmr_en;
				tmr_read[`TMR_CTRL_PEND] = tmr_pend;
			end
			default: tmr_read = '0;
		endcase
	end

	// Read value captured on the accept edge
	always_ff @(posedge clock)
	begin
		if (tmr_accept)
			tmr_rdata <= tmr_read;
	end

	assign timer_bus.ready = tmr_ready;
	assign timer_bus.rdata = tmr_rdata;
	assign o_timer_irq = tmr_pend;

endmodule

// ==== rtl/soc_fabric.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module soc_fabric
(
	input logic clock,
	input logic i_rst_n,

	// Instruction fetch
	input logic i_ib_request,
	input soc_bus_pkg::addr_t i_ib_address,
	output logic o_ib_ready,
	output soc_bus_pkg::data_t o_ib_rdata,

	// Data access
	input logic i_db_request,
	input logic i_db_rw,
	input soc_bus_pkg::addr_t i_db_address,
	input soc_bus_pkg::data_t i_db_wdata,
	output logic o_db_ready,
	output soc_bus_pkg::data_t o_db_rdata,

	// DMA
	input logic i_dma_request,
	input logic i_dma_rw,
	input soc_bus_pkg::addr_t i_dma_address,
	input soc_bus_pkg::data_t i_dma_wdata,
	output logic o_dma_ready,
	output soc_bus_pkg::data_t o_dma_rdata,

	output soc_periph_pkg::led_t o_led,
	output logic o_timer_irq
);

	// Shared bus and one segment per target
	mem_bus_if sys_bus ();
	mem_bus_if ram_bus ();
	mem_bus_if led_bus ();
	mem_bus_if timer_bus ();

	bus_arbiter arbiter0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ib_request(i_ib_request),
		.i_ib_address(i_ib_address),
		.o_ib_ready(o_ib_ready),
		.o_ib_rdata(o_ib_rdata),
		.i_db_request(i_db_request),
		.i_db_rw(i_db_rw),
		.i_db_address(i_db_address),
		.i_db_wdata(i_db_wdata),
		.o_db_ready(o_db_ready),
		.o_db_rdata(o_db_rdata),
		.i_dma_request(i_dma_request),
		.i_dma_rw(i_dma_rw),
		.i_dma_address(i_dma_address),
		.i_dma_wdata(i_dma_wdata),
		.o_dma_ready(o_dma_ready),
		.o_dma_rdata(o_dma_rdata),
		.bus(sys_bus.master)
	);

	bus_decoder decoder0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.up(sys_bus.slave),
		.ram_bus(ram_bus.master),
		.led_bus(led_bus.master),
		.timer_bus(timer_bus.master)
	);

	//============================================================
	// Targets

	ram_block #(
		.WORDS(`RAM_WORDS)
	) ram0 (
		.clock(clock),
		.bus(ram_bus.slave)
	);

	io_regs io0 (
		.clock(clock),
		.i_rst_n(i_rst_n),
		.led_bus(led_bus.slave),
		.timer_bus(timer_bus.slave),
		.o_led(o_led),
		.o_timer_irq(o_timer_irq)
	);

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 5
)
(
	output logic o_clock,
	output logic o_rst_n
);

	initial
	begin
		o_clock = 1'b0;
		forever
			#(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Reset low for the first cycles, released just after a rising edge
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge o_clock);
		#1;
		o_rst_n = 1'b1;
	end

endmodule

// ==== dv/tb_soc_fabric.sv ====
`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc_fabric;

	localparam logic [31:0] SEED = 32'h3ae0_c5b5;
	// About 95 accesses of 4 cycles plus under 100 cycles of timer waits, with a wide margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic clock;
	logic rst_n;

	logic ib_request;
	soc_bus_pkg::addr_t ib_address;
	logic ib_ready;
	soc_bus_pkg::data_t ib_rdata;
	logic db_request;
	logic db_rw;
	soc_bus_pkg::addr_t db_address;
	soc_bus_pkg::data_t db_wdata;
	logic db_ready;
	soc_bus_pkg::data_t db_rdata;
	logic dma_request;
	logic dma_rw;
	soc_bus_pkg::addr_t dma_address;
	soc_bus_pkg::data_t dma_wdata;
	logic dma_ready;
	soc_bus_pkg::data_t dma_rdata;
	soc_periph_pkg::led_t led;
	logic timer_irq;

	// Expected state of the mapped targets
	soc_bus_pkg::data_t ram_sh [`RAM_WORDS];
	soc_periph_pkg::led_t led_sh;
	soc_periph_pkg::timer_cnt_t cmp_sh;
	logic en_sh;
	logic pend_sh;

	// Completed reads waiting for the compare process
	string rd_name_q [$];
	soc_bus_pkg::addr_t rd_addr_q [$];
	soc_bus_pkg::data_t rd_data_q [$];
	soc_bus_pkg::master_t done_order [$];
	int posted = 0;
	int checked = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int checks_mark = 0;
	int errors_mark = 0;
	int cycle_count = 0;

	tb_clock_gen clkgen0 (
		.o_clock(clock),
		.o_rst_n(rst_n)
	);

	soc_fabric dut0 (
		.clock(clock),
		.i_rst_n(rst_n),
		.i_ib_request(ib_request),
		.i_ib_address(ib_address),
		.o_ib_ready(ib_ready),
		.o_ib_rdata(ib_rdata),
		.i_db_request(db_request),
		.i_db_rw(db_rw),
		.i_db_address(db_address),
		.i_db_wdata(db_wdata),
		.o_db_ready(db_ready),
		.o_db_rdata(db_rdata),
		.i_dma_request(dma_request),
		.i_dma_rw(dma_rw),
		.i_dma_address(dma_address),
		.i_dma_wdata(dma_wdata),
		.o_dma_ready(dma_ready),
		.o_dma_rdata(dma_rdata),
		.o_led(led),
		.o_timer_irq(timer_irq)
	);

	//============================================================
	// Reference model

	function automatic soc_bus_pkg::addr_t region_addr(soc_bus_pkg::region_t region,
		logic [`SOC_REGION_LSB-1:0] offset);
		return {region, offset};
	endfunction

	function automatic soc_bus_pkg::addr_t timer_addr(soc_periph_pkg::reg_idx_t idx);
		return {`REGION_TIMER, 24'd0, idx, 2'b00};
	endfunction

	// Expected read value from the shadows and the region and timer rules
	function automatic soc_bus_pkg::data_t ref_read(soc_bus_pkg::addr_t addr);
		soc_bus_pkg::region_t region;
		soc_periph_pkg::reg_idx_t idx;
		soc_bus_pkg::data_t value;
		region = addr[`SOC_ADDR_W-1:`SOC_REGION_LSB];
		idx = addr[3:2];
		value = '0;
		case (region)
			`REGION_RAM: value = ram_sh[(addr >> 2) % `RAM_WORDS];
			`REGION_LED: value = {{(`SOC_DATA_W-`LED_W){1'b0}}, led_sh};
			`REGION_TIMER:
			begin
				if (idx == `TMR_REG_COMPARE)
					value = cmp_sh;
				else if (idx == `TMR_REG_CTRL)
				begin
					value[`TMR_CTRL_EN] = en_sh;
					value[`TMR_CTRL_PEND] = pend_sh;
				end
			end
			// Unmapped regions read as zero
			default: value = '0;
		endcase
		return value;
	endfunction

	task automatic update_shadow(soc_bus_pkg::addr_t addr, soc_bus_pkg::data_t wdata);
		case (addr[`SOC_ADDR_W-1:`SOC_REGION_LSB])
			`REGION_RAM: ram_sh[(addr >> 2) % `RAM_WORDS] = wdata;
			`REGION_LED: led_sh = wdata[`LED_W-1:0];
			`REGION_TIMER:
			begin
				if (addr[3:2] == `TMR_REG_COMPARE)
					cmp_sh = wdata;
				else if (addr[3:2] == `TMR_REG_CTRL)
				begin
					en_sh = wdata[`TMR_CTRL_EN];
					if (wdata[`TMR_CTRL_PEND])
						pend_sh = 1'b0;
				end
			end
			default: ;
		endcase
	endtask

	//============================================================
	// Checks

	task automatic check_value(string name, soc_bus_pkg::data_t expected,
		soc_bus_pkg::data_t actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(logic cond, string what);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic post_read(string name, soc_bus_pkg::addr_t addr, soc_bus_pkg::data_t data);
		rd_name_q.push_back(name);
		rd_addr_q.push_back(addr);
		rd_data_q.push_back(data);
		posted++;
	endtask

	// Compares every completed read against the reference model
	initial
	begin : compare_reads
		string name;
		soc_bus_pkg::addr_t addr;
		soc_bus_pkg::data_t actual;
		forever
		begin
			wait (posted != checked);
			name = rd_name_q.pop_front();
			addr = rd_addr_q.pop_front();
			actual = rd_data_q.pop_front();
			check_value(name, ref_read(addr), actual);
			checked++;
		end
	end

	task automatic finish_test(string name);
		wait (posted == checked);
		tests++;
		$display("%s done: %0d checks, %0d errors", name, checks - checks_mark,
			errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	//============================================================
	// Port access

	task automatic drive_port(soc_bus_pkg::master_t port, logic req, logic rw,
		soc_bus_pkg::addr_t addr, soc_bus_pkg::data_t wdata);
		case (port)
			soc_bus_pkg::M_DATA:
			begin
				db_request = req;
				db_rw = rw;
				db_address = addr;
				db_wdata = wdata;
			end
			soc_bus_pkg::M_DMA:
			begin
				dma_request = req;
				dma_rw = rw;
				dma_address = addr;
				dma_wdata = wdata;
			end
			default:
			begin
				ib_request = req;
				ib_address = addr;
			end
		endcase
	endtask

	function automatic logic port_ready(soc_bus_pkg::master_t port);
		case (port)
			soc_bus_pkg::M_DATA: return db_ready;
			soc_bus_pkg::M_DMA: return dma_ready;
			default: return ib_ready;
		endcase
	endfunction

	function automatic soc_bus_pkg::data_t port_rdata(soc_bus_pkg::master_t port);
		case (port)
			soc_bus_pkg::M_DATA: return db_rdata;
			soc_bus_pkg::M_DMA: return dma_rdata;
			default: return ib_rdata;
		endcase
	endfunction

	// One access, latency counted in rising edges from request to ready
	task automatic bus_access(input soc_bus_pkg::master_t port, input logic rw,
		input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
		input string name, output int latency);
		soc_bus_pkg::data_t rdata;
		@(posedge clock);
		#1;
		drive_port(port, 1'b1, rw, addr, wdata);
		latency = 0;
		do
		begin
			@(posedge clock);
			latency++;
			@(negedge clock);
		end
		while (!port_ready(port));
		rdata = port_rdata(port);
		done_order.push_back(port);
		if (rw && port != soc_bus_pkg::M_INSTR)
			update_shadow(addr, wdata);
		else
			post_read(name, addr, rdata);
		@(posedge clock);
		#1;
		drive_port(port, 1'b0, 1'b0, '0, '0);
	endtask

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$finish;
		end
	end

	//============================================================
	// Tests

	initial
	begin : run_tests
		int lat;
		int lat_dma;
		int lat_ib;
		int seed_val;
		int wait_cycles;
		logic irq_seen;
		soc_bus_pkg::addr_t addrs [32];
		soc_bus_pkg::addr_t addr;
		soc_bus_pkg::data_t wdata;
		soc_bus_pkg::region_t unmapped [3];

		drive_port(soc_bus_pkg::M_DATA, 1'b0, 1'b0, '0, '0);
		drive_port(soc_bus_pkg::M_DMA, 1'b0, 1'b0, '0, '0);
		drive_port(soc_bus_pkg::M_INSTR, 1'b0, 1'b0, '0, '0);
		led_sh = '0;
		cmp_sh = '0;
		en_sh = 1'b0;
		pend_sh = 1'b0;
		seed_val = $urandom(SEED);

		wait (rst_n === 1'b1);
		@(negedge clock);
		check_true(!db_ready && !dma_ready && !ib_ready, "A ready output is high after reset");
		check_true(!timer_irq, "Timer interrupt is high after reset");
		check_value("led_reset", '0, {{(`SOC_DATA_W-`LED_W){1'b0}}, led});
		// Timer comes out of reset disabled with nothing pending
		bus_access(soc_bus_pkg::M_DATA, 1'b0, timer_addr(`TMR_REG_CTRL), '0,
			"timer_ctrl_reset", lat);
		finish_test("reset");

		// RAM through the data port, reads vary the bits above the word index
		for (int i = 0; i < 32; i++)
		begin
			addr = $urandom();
			addr[`SOC_ADDR_W-1:`SOC_REGION_LSB] = `REGION_RAM;
			addr[1:0] = 2'b00;
			addrs[i] = addr;
			wdata = $urandom();
			bus_access(soc_bus_pkg::M_DATA, 1'b1, addr, wdata, "ram_write", lat);
			check_value("ram_write_latency", 32'd2, lat);
		end
		for (int i = 0; i < 32; i++)
		begin
			addr = addrs[i];
			addr[27:12] = 16'($urandom());
			bus_access(soc_bus_pkg::M_DATA, 1'b0, addr, '0, "ram_read", lat);
			check_value("ram_read_latency", 32'd2, lat);
		end
		finish_test("ram_rw");

		wdata = $urandom();
		bus_access(soc_bus_pkg::M_DATA, 1'b1, region_addr(`REGION_LED, '0), wdata, "led_w", lat);
		@(negedge clock);
		check_value("led_pins", {{(`SOC_DATA_W-`LED_W){1'b0}}, led_sh},
			{{(`SOC_DATA_W-`LED_W){1'b0}}, led});
		bus_access(soc_bus_pkg::M_DATA, 1'b0, region_addr(`REGION_LED, 28'h10), '0,
			"led_read", lat);
		finish_test("led");

		// All three ports start in the same cycle
		for (int i = 0; i < 3; i++)
			bus_access(soc_bus_pkg::M_DATA, 1'b1, region_addr(`REGION_RAM, 28'h100 + 4 * i),
				$urandom(), "contend_init", lat);
		done_order.delete();
		fork
			bus_access(soc_bus_pkg::M_DATA, 1'b0, region_addr(`REGION_RAM, 28'h100), '0,
				"contend_data", lat);
			bus_access(soc_bus_pkg::M_DMA, 1'b0, region_addr(`REGION_RAM, 28'h104), '0,
				"contend_dma", lat_dma);
			bus_access(soc_bus_pkg::M_INSTR, 1'b0, region_addr(`REGION_RAM, 28'h108), '0,
				"contend_instr", lat_ib);
		join
		check_true(done_order.size() == 3 && done_order[0] == soc_bus_pkg::M_DATA &&
			done_order[1] == soc_bus_pkg::M_DMA && done_order[2] == soc_bus_pkg::M_INSTR,
			"Ready pulses did not follow the order data, DMA, instruction");
		// Data port finds the bus idle, the others are held back
		check_value("contend_data_latency", 32'd2, lat);
		check_true(lat_dma > lat && lat_ib > lat_dma,
			"Lower-priority ports were not held back while a higher port used the bus");
		finish_test("contention");

		bus_access(soc_bus_pkg::M_DATA, 1'b1, region_addr(`REGION_RAM, 28'h200), $urandom(),
			"share_w0", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b1, region_addr(`REGION_RAM, 28'h204), $urandom(),
			"share_w1", lat);
		bus_access(soc_bus_pkg::M_DMA, 1'b0, region_addr(`REGION_RAM, 28'h200), '0,
			"dma_read", lat);
		bus_access(soc_bus_pkg::M_INSTR, 1'b0, region_addr(`REGION_RAM, 28'h204), '0,
			"instr_read", lat);
		bus_access(soc_bus_pkg::M_DMA, 1'b1, region_addr(`REGION_RAM, 28'h208), $urandom(),
			"dma_write", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b0, region_addr(`REGION_RAM, 28'h208), '0,
			"data_read_dma_word", lat);
		finish_test("shared_ram");

		// Unmapped accesses complete and leave the mapped state alone
		unmapped[0] = 4'h2;
		unmapped[1] = 4'h5;
		unmapped[2] = 4'hF;
		for (int i = 0; i < 3; i++)
		begin
			addr = region_addr(unmapped[i], 28'h100);
			bus_access(soc_bus_pkg::M_DATA, 1'b1, addr, $urandom(), "unmapped_w", lat);
			bus_access(soc_bus_pkg::M_DATA, 1'b0, addr, '0, "unmapped_read", lat);
		end
		bus_access(soc_bus_pkg::M_DATA, 1'b0, region_addr(`REGION_LED, '0), '0,
			"unmapped_led_kept", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b0, region_addr(`REGION_RAM, 28'h100), '0,
			"unmapped_ram_kept", lat);
		finish_test("unmapped");

		bus_access(soc_bus_pkg::M_DATA, 1'b1, timer_addr(`TMR_REG_COMPARE), 32'd20,
			"tmr_cmp_w", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b1, timer_addr(`TMR_REG_CTRL), 32'h1, "tmr_en_w", lat);
		@(negedge clock);
		check_true(!timer_irq, "Timer interrupt rose right at enable");
		wait_cycles = 0;
		while (!timer_irq && wait_cycles < 25)
		begin
			@(posedge clock);
			wait_cycles++;
			@(negedge clock);
		end
		check_true(timer_irq, "Timer interrupt did not rise within 25 cycles of enable");
		// Count from zero matches compare after compare+1 cycles and sets pending
		pend_sh = 1'b1;
		bus_access(soc_bus_pkg::M_DATA, 1'b0, timer_addr(`TMR_REG_COMPARE), '0,
			"timer_compare_read", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b0, timer_addr(`TMR_REG_CTRL), '0,
			"timer_ctrl_pending", lat);
		bus_access(soc_bus_pkg::M_DATA, 1'b1, timer_addr(`TMR_REG_CTRL), 32'h2, "tmr_clr_w", lat);
		@(negedge clock);
		check_true(!timer_irq, "Timer interrupt still high after clearing pending");
		irq_seen = 1'b0;
		repeat (50)
		begin
			@(posedge clock);
			@(negedge clock);
			if (timer_irq)
				irq_seen = 1'b1;
		end
		check_true(!irq_seen, "Timer interrupt came while the timer was disabled");
		bus_access(soc_bus_pkg::M_DATA, 1'b0, timer_addr(`TMR_REG_CTRL), '0,
			"timer_ctrl_idle", lat);
		finish_test("timer");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/soc_periph_pkg.sv
rtl/mem_bus_if.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/ram_block.sv
rtl/io_regs.sv
rtl/soc_fabric.sv
dv/tb_clock_gen.sv
dv/tb_soc_fabric.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_soc_fabric
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= test failed
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || { cat $(LOG); echo "Simulator exited with an error"; exit 1; }
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG) FAIL_MSG="$(FAIL_MSG)"

check:
	@test -f $(LOG) || { echo "No log file $(LOG)"; exit 1; }
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@echo "No failure found in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
